// ==== common/mmu_pkg.sv ====
`default_nettype none

package mmu_pkg;

  // ==============================
  // Sv39 widths
  // ==============================
  localparam int VADDR_WIDTH       = 39;
  localparam int PADDR_WIDTH       = 56;
  localparam int PAGE_OFFSET_WIDTH = 12;
  localparam int VPN_WIDTH         = 27;
  localparam int PPN_WIDTH         = 44;
  localparam int PTE_WIDTH         = 64;
  localparam int LEVELS            = 3;
  localparam int LEVEL_WIDTH       = $clog2(LEVELS);
  localparam int VPN_SLICE_WIDTH   = 9;

  typedef enum logic [1:0] {
    priv_user  = 2'd0,
    priv_super = 2'd1
  } priv_e;

  typedef enum logic [1:0] {
    access_fetch = 2'd0,
    access_load  = 2'd1,
    access_store = 2'd2
  } access_e;

  typedef enum logic [1:0] {
    fault_none       = 2'd0,
    fault_instr_page = 2'd1,
    fault_load_page  = 2'd2,
    fault_store_page = 2'd3
  } fault_e;

  // ==============================
  // page table entry
  // ==============================
  typedef struct packed {
    logic [9:0]           rsvd;
    logic [PPN_WIDTH-1:0] ppn;
    logic [1:0]           rsw;
    logic                 d;
    logic                 a;
    logic                 g;
    logic                 u;
    logic                 x;
    logic                 w;
    logic                 r;
    logic                 v;
  } pte_s;

  // leaf as cached in the TLB.
  typedef struct packed {
    logic [PPN_WIDTH-1:0] ppn;
    logic                 u;
    logic                 x;
    logic                 w;
    logic                 r;
    logic                 a;
    logic                 d;
  } tlb_entry_s;

  typedef struct packed {
    logic [VADDR_WIDTH-1:0] vaddr;
    access_e                access;
    priv_e                  priv;
  } mmu_req_s;

endpackage

`default_nettype wire

// ==== common/walk_pkg.sv ====
`default_nettype none

package walk_pkg;

  typedef enum logic [2:0] {
    walk_idle = 3'd0,
    walk_send = 3'd1,
    walk_wait = 3'd2,
    walk_fill = 3'd3
  } walk_state_e;

  localparam int PTE_MEM_DEPTH     = 2048;
  localparam int PTE_ADDR_WIDTH    = $clog2(PTE_MEM_DEPTH);
  localparam int MEM_CREDITS       = 2;
  localparam int MEM_CREDIT_WIDTH  = $clog2(MEM_CREDITS + 1);
  localparam int QUEUE_PTR_WIDTH   = $clog2(MEM_CREDITS);
  localparam int CLIENT_CREDITS    = 1;
  localparam int MEM_LATENCY       = 2;
  localparam int TLB_ENTRIES       = 8;
  localparam int TLB_IDX_WIDTH     = $clog2(TLB_ENTRIES);

  typedef struct packed {
    logic [PTE_ADDR_WIDTH-1:0] addr;
  } mem_req_s;

  typedef struct packed {
    mmu_pkg::pte_s pte;
  } mem_rsp_s;

  typedef struct packed {
    logic [mmu_pkg::VPN_WIDTH-1:0] vpn;
  } walk_req_s;

  typedef struct packed {
    logic [mmu_pkg::VPN_WIDTH-1:0] vpn;
    mmu_pkg::tlb_entry_s           entry;
    logic                          walk_fault;
  } walk_fill_s;

endpackage

`default_nettype wire

// ==== ptw/ptw_walker.sv ====
`timescale 1ns/1ns
`default_nettype none

module ptw_walker (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic [mmu_pkg::PPN_WIDTH-1:0]     base_ppn_i,
  input  logic                              translation_en_i,
  input  logic                              walk_v_i,
  input  walk_pkg::walk_req_s               walk_i,
  output logic                              fill_v_o,
  output walk_pkg::walk_fill_s              fill_o,
  output logic                              mem_req_v_o,
  output walk_pkg::mem_req_s                mem_req_o,
  input  logic                              mem_rsp_v_i,
  input  walk_pkg::mem_rsp_s                mem_rsp_i,
  input  logic                              mem_credit_i,
  output logic                              busy_o
);
  import mmu_pkg::*;
  import walk_pkg::*;

  walk_state_e                          state_r, state_n;
  logic [MEM_CREDIT_WIDTH-1:0]          credits_r;
  logic [LEVEL_WIDTH-1:0]               level_r;
  logic [VPN_WIDTH-1:0]                 vpn_r;
  logic [PPN_WIDTH-1:0]                 ppn_r;
  walk_fill_s                           fill_r;

  pte_s                                 pte;
  logic [VPN_SLICE_WIDTH-1:0]           vpn_slice;
  logic [PPN_WIDTH+VPN_SLICE_WIDTH-1:0] pte_addr_full;
  logic [PPN_WIDTH-1:0]                 leaf_ppn;
  logic                                 start;
  logic                                 pte_leaf;
  logic                                 misaligned;
  logic                                 walk_fault;
  logic                                 walk_done;

  // ==============================
  // PTE decode
  // ==============================
  assign pte           = mem_rsp_i.pte;
  assign vpn_slice     = vpn_r[level_r*VPN_SLICE_WIDTH +: VPN_SLICE_WIDTH];
  assign pte_addr_full = {ppn_r, vpn_slice}; // ppn * 512 + slice.
  assign pte_leaf      = pte.r | pte.w | pte.x;

  // superpage ppn borrows its low slices from the vpn.
  always_comb begin
    leaf_ppn   = pte.ppn;
    misaligned = 1'b0;
    for (int i = 0; i < LEVELS - 1; i++) begin
      if (level_r > i) begin
        leaf_ppn[i*VPN_SLICE_WIDTH +: VPN_SLICE_WIDTH] =
          vpn_r[i*VPN_SLICE_WIDTH +: VPN_SLICE_WIDTH];
        misaligned = misaligned | (|pte.ppn[i*VPN_SLICE_WIDTH +: VPN_SLICE_WIDTH]);
      end
    end
  end

  assign walk_fault = ~pte.v
                    | (pte.w & ~pte.r)
                    | (~pte_leaf & (level_r == '0))
                    | (pte_leaf & misaligned)
                    | (pte_leaf & ~pte.a);
  assign walk_done  = pte_leaf | walk_fault;

  // ==============================
  // FSM
  // ==============================
  assign start = (state_r == walk_idle) & walk_v_i;

  always_comb begin
    case (state_r)
      walk_idle: begin
        if (walk_v_i) begin
          state_n = translation_en_i ? walk_send : walk_fill;
        end else begin
          state_n = walk_idle;
        end
      end
      walk_send: state_n = (credits_r != '0) ? walk_wait : walk_send;
      walk_wait: begin
        if (mem_rsp_v_i) begin
          state_n = walk_done ? walk_fill : walk_send;
        end else begin
          state_n = walk_wait;
        end
      end
      walk_fill: state_n = walk_idle;
      default:   state_n = walk_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= walk_idle;
      credits_r <= MEM_CREDIT_WIDTH'(MEM_CREDITS);
      level_r   <= '0;
    end else begin
      state_r   <= state_n;
      credits_r <= credits_r - MEM_CREDIT_WIDTH'(mem_req_v_o)
                             + MEM_CREDIT_WIDTH'(mem_credit_i);
      if (start) begin
        level_r <= LEVEL_WIDTH'(LEVELS - 1);
      end else if ((state_r == walk_wait) && mem_rsp_v_i && !walk_done) begin
        level_r <= level_r - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      vpn_r <= walk_i.vpn;
      ppn_r <= base_ppn_i;
      // identity leaf with full rights when translation is off.
      fill_r.vpn        <= walk_i.vpn;
      fill_r.entry.ppn  <= PPN_WIDTH'(walk_i.vpn);
      fill_r.entry.u    <= 1'b0;
      fill_r.entry.x    <= 1'b1;
      fill_r.entry.w    <= 1'b1;
      fill_r.entry.r    <= 1'b1;
      fill_r.entry.a    <= 1'b1;
      fill_r.entry.d    <= 1'b1;
      fill_r.walk_fault <= 1'b0;
    end else if ((state_r == walk_wait) && mem_rsp_v_i) begin
      if (walk_done) begin
        fill_r.vpn        <= vpn_r;
        fill_r.entry.ppn  <= leaf_ppn;
        fill_r.entry.u    <= pte.u;
        fill_r.entry.x    <= pte.x;
        fill_r.entry.w    <= pte.w;
        fill_r.entry.r    <= pte.r;
        fill_r.entry.a    <= pte.a;
        fill_r.entry.d    <= pte.d;
        fill_r.walk_fault <= walk_fault;
      end else begin
        ppn_r <= pte.ppn; // descend one level.
      end
    end
  end

  assign mem_req_v_o    = (state_r == walk_send) & (credits_r != '0);
  assign mem_req_o.addr = pte_addr_full[PTE_ADDR_WIDTH-1:0];
  assign fill_v_o       = (state_r == walk_fill);
  assign fill_o         = fill_r;
  assign busy_o         = (state_r != walk_idle);

  // ==============================
  // assertions
  // ==============================
  a_credit_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    credits_r <= MEM_CREDIT_WIDTH'(MEM_CREDITS));

  // one read in flight, so a send never finds the credits used up.
  a_req_has_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == walk_send) |-> (credits_r != '0));

  a_state_legal: assert property (@(posedge clk_i) disable iff (reset_i)
    state_r inside {walk_idle, walk_send, walk_wait, walk_fill});

endmodule

`default_nettype wire

// ==== rtl/tlb_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module tlb_stage (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            req_v_i,
  input  mmu_pkg::mmu_req_s               req_i,
  output logic                            credit_o,
  output logic                            resp_v_o,
  output logic [mmu_pkg::PADDR_WIDTH-1:0] resp_paddr_o,
  output mmu_pkg::fault_e                 resp_fault_o,
  input  logic                            flush_i,
  input  logic                            translation_en_i,
  output logic                            walk_v_o,
  output walk_pkg::walk_req_s             walk_o,
  input  logic                            fill_v_i,
  input  walk_pkg::walk_fill_s            fill_i
);
  import mmu_pkg::*;
  import walk_pkg::*;

  mmu_req_s                 req_r;
  logic                     req_pend_r;
  logic                     walk_wait_r;
  logic                     walk_v_r;
  logic [TLB_ENTRIES-1:0]   valid_r;
  logic [VPN_WIDTH-1:0]     tag_r [TLB_ENTRIES];
  tlb_entry_s               entry_r [TLB_ENTRIES];
  logic [TLB_IDX_WIDTH-1:0] victim_r;
  logic                     resp_v_r;
  logic [PADDR_WIDTH-1:0]   resp_paddr_r;
  fault_e                   resp_fault_r;

  logic [VPN_WIDTH-1:0]     req_vpn;
  logic [TLB_ENTRIES-1:0]   hit_vec;
  logic                     hit;
  tlb_entry_s               hit_entry;
  logic                     fill_take;
  logic                     fill_ok;

  function automatic fault_e access_fault(access_e kind);
    case (kind)
      access_fetch: return fault_instr_page;
      access_load:  return fault_load_page;
      default:      return fault_store_page;
    endcase
  endfunction

  // SUM and MXR are tied off.
  function automatic fault_e check_perm(tlb_entry_s e, mmu_req_s r);
    logic deny;
    deny = ~e.a | ((r.priv == priv_super) & e.u);
    case (r.access)
      access_fetch: deny = deny | ~e.x;
      access_load:  deny = deny | ~e.r;
      default:      deny = deny | ~(e.w & e.d);
    endcase
    return deny ? access_fault(r.access) : fault_none;
  endfunction

  // ==============================
  // lookup
  // ==============================
  assign req_vpn = req_r.vaddr[VADDR_WIDTH-1:PAGE_OFFSET_WIDTH];

  always_comb begin
    hit_entry = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      hit_vec[i] = valid_r[i] & (tag_r[i] == req_vpn);
      if (hit_vec[i]) begin
        hit_entry = entry_r[i];
      end
    end
  end

  assign hit       = translation_en_i & (|hit_vec); // no hits while bare.
  assign fill_take = walk_wait_r & fill_v_i;
  assign fill_ok   = fill_take & ~fill_i.walk_fault & translation_en_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_pend_r  <= 1'b0;
      walk_wait_r <= 1'b0;
      walk_v_r    <= 1'b0;
      resp_v_r    <= 1'b0;
      valid_r     <= '0;
      victim_r    <= '0;
    end else begin
      req_pend_r <= req_v_i;
      walk_v_r   <= req_pend_r & ~hit;
      resp_v_r   <= (req_pend_r & hit) | fill_take;
      if (req_pend_r && !hit) begin
        walk_wait_r <= 1'b1;
      end else if (fill_take) begin
        walk_wait_r <= 1'b0;
      end
      if (flush_i) begin
        valid_r <= '0;
      end else if (fill_ok) begin
        valid_r[victim_r] <= 1'b1;
      end
      if (fill_ok) begin
        victim_r <= victim_r + 1'b1; // round robin.
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      req_r <= req_i;
    end
    if (fill_ok) begin
      tag_r[victim_r]   <= fill_i.vpn;
      entry_r[victim_r] <= fill_i.entry;
    end
    if (req_pend_r && hit) begin
      resp_paddr_r <= {hit_entry.ppn, req_r.vaddr[PAGE_OFFSET_WIDTH-1:0]};
      resp_fault_r <= check_perm(hit_entry, req_r);
    end else if (fill_take) begin
      resp_paddr_r <= {fill_i.entry.ppn, req_r.vaddr[PAGE_OFFSET_WIDTH-1:0]};
      resp_fault_r <= fill_i.walk_fault ? access_fault(req_r.access)
                                        : check_perm(fill_i.entry, req_r);
    end
  end

  assign walk_v_o     = walk_v_r;
  assign walk_o.vpn   = req_vpn;
  assign resp_v_o     = resp_v_r;
  assign credit_o     = resp_v_r; // credit goes back with the response.
  assign resp_paddr_o = resp_paddr_r;
  assign resp_fault_o = resp_fault_r;

endmodule

`default_nettype wire

// ==== rtl/pte_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module pte_mem (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                mem_req_v_i,
  input  walk_pkg::mem_req_s                  mem_req_i,
  output logic                                mem_rsp_v_o,
  output walk_pkg::mem_rsp_s                  mem_rsp_o,
  output logic                                mem_credit_o,
  input  logic                                pre_v_i,
  input  logic [walk_pkg::PTE_ADDR_WIDTH-1:0] pre_addr_i,
  input  mmu_pkg::pte_s                       pre_data_i
);
  import mmu_pkg::*;
  import walk_pkg::*;

  mem_req_s                    queue_r [MEM_CREDITS];
  logic [QUEUE_PTR_WIDTH-1:0]  head_r;
  logic [QUEUE_PTR_WIDTH-1:0]  tail_r;
  logic [MEM_CREDIT_WIDTH-1:0] count_r;
  pte_s                        mem_r [PTE_MEM_DEPTH];
  logic [MEM_LATENCY-1:0]      pipe_v_r;
  pte_s                        pipe_r [MEM_LATENCY];
  logic                        pop;

  assign pop = (count_r != '0); // one read per cycle.

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_r   <= '0;
      tail_r   <= '0;
      count_r  <= '0;
      pipe_v_r <= '0;
    end else begin
      count_r  <= count_r + MEM_CREDIT_WIDTH'(mem_req_v_i) - MEM_CREDIT_WIDTH'(pop);
      head_r   <= head_r + QUEUE_PTR_WIDTH'(pop);
      tail_r   <= tail_r + QUEUE_PTR_WIDTH'(mem_req_v_i);
      pipe_v_r <= {pipe_v_r[MEM_LATENCY-2:0], pop};
    end
  end

  // ==============================
  // queue, array and delay pipe
  // ==============================
  always_ff @(posedge clk_i) begin
    if (mem_req_v_i) begin
      queue_r[tail_r] <= mem_req_i;
    end
    if (pre_v_i) begin
      mem_r[pre_addr_i] <= pre_data_i;
    end
    pipe_r[0] <= mem_r[queue_r[head_r].addr];
    for (int i = 1; i < MEM_LATENCY; i++) begin
      pipe_r[i] <= pipe_r[i-1];
    end
  end

  assign mem_rsp_v_o   = pipe_v_r[MEM_LATENCY-1];
  assign mem_rsp_o.pte = pipe_r[MEM_LATENCY-1];
  assign mem_credit_o  = pop;

  a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_v_i |-> (count_r < MEM_CREDIT_WIDTH'(MEM_CREDITS)));

endmodule

`default_nettype wire

// ==== rtl/mmu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mmu_top (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                req_v_i,
  input  mmu_pkg::mmu_req_s                   req_i,
  output logic                                credit_o,
  output logic                                resp_v_o,
  output logic [mmu_pkg::PADDR_WIDTH-1:0]     resp_paddr_o,
  output mmu_pkg::fault_e                     resp_fault_o,
  input  logic [mmu_pkg::PPN_WIDTH-1:0]       base_ppn_i,
  input  logic                                translation_en_i,
  input  logic                                flush_i,
  input  logic                                pre_v_i,
  input  logic [walk_pkg::PTE_ADDR_WIDTH-1:0] pre_addr_i,
  input  mmu_pkg::pte_s                       pre_data_i,
  output logic                                busy_o
);
  import walk_pkg::*;

  logic       walk_v;
  walk_req_s  walk;
  logic       fill_v;
  walk_fill_s fill;
  logic       mem_req_v;
  mem_req_s   mem_req;
  logic       mem_rsp_v;
  mem_rsp_s   mem_rsp;
  logic       mem_credit;

  tlb_stage u_tlb (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .req_v_i          (req_v_i),
    .req_i            (req_i),
    .credit_o         (credit_o),
    .resp_v_o         (resp_v_o),
    .resp_paddr_o     (resp_paddr_o),
    .resp_fault_o     (resp_fault_o),
    .flush_i          (flush_i),
    .translation_en_i (translation_en_i),
    .walk_v_o         (walk_v),
    .walk_o           (walk),
    .fill_v_i         (fill_v),
    .fill_i           (fill)
  );

  ptw_walker u_walker (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .base_ppn_i       (base_ppn_i),
    .translation_en_i (translation_en_i),
    .walk_v_i         (walk_v),
    .walk_i           (walk),
    .fill_v_o         (fill_v),
    .fill_o           (fill),
    .mem_req_v_o      (mem_req_v),
    .mem_req_o        (mem_req),
    .mem_rsp_v_i      (mem_rsp_v),
    .mem_rsp_i        (mem_rsp),
    .mem_credit_i     (mem_credit),
    .busy_o           (busy_o)
  );

  pte_mem u_mem (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .mem_req_v_i  (mem_req_v),
    .mem_req_i    (mem_req),
    .mem_rsp_v_o  (mem_rsp_v),
    .mem_rsp_o    (mem_rsp),
    .mem_credit_o (mem_credit),
    .pre_v_i      (pre_v_i),
    .pre_addr_i   (pre_addr_i),
    .pre_data_i   (pre_data_i)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== tests/mmu_model.svh ====
`ifndef MMU_MODEL_SVH
`define MMU_MODEL_SVH

// ==============================
// shadow table and reference
// ==============================
typedef struct packed {
  logic [PADDR_WIDTH-1:0] paddr;
  fault_e                 fault;
} expect_s;

pte_s shadow_mem [PTE_MEM_DEPTH]; // mirrors every preload write.

// flag byte holds d a g u x w r v from bit 7 down.
function automatic pte_s make_pte(logic [PPN_WIDTH-1:0] ppn, logic [7:0] flags);
  return {10'd0, ppn, 2'd0, flags};
endfunction

function automatic expect_s ref_translate(mmu_req_s r, logic en, logic [PPN_WIDTH-1:0] base);
  expect_s              res;
  pte_s                 pte;
  logic [PPN_WIDTH-1:0] ppn;
  logic [PPN_WIDTH-1:0] vpn;
  logic [PPN_WIDTH-1:0] low_mask;
  fault_e               kind;
  logic                 deny;
  case (r.access)
    access_fetch: kind = fault_instr_page;
    access_load:  kind = fault_load_page;
    default:      kind = fault_store_page;
  endcase
  vpn       = PPN_WIDTH'(r.vaddr >> PAGE_OFFSET_WIDTH);
  res.paddr = PADDR_WIDTH'(r.vaddr); // bare mode is identity.
  res.fault = fault_none;
  if (!en) begin
    return res;
  end
  ppn = base;
  for (int lvl = LEVELS - 1; lvl >= 0; lvl--) begin
    // tables live in ppn 0 to 3.
    pte = shadow_mem[int'(ppn[1:0]) * 512 + int'(vpn[lvl*VPN_SLICE_WIDTH +: VPN_SLICE_WIDTH])];
    if (!pte.v || (pte.w && !pte.r)) begin
      res.fault = kind;
      return res;
    end
    if (pte.r || pte.w || pte.x) begin
      low_mask = (PPN_WIDTH'(1) << (lvl * VPN_SLICE_WIDTH)) - PPN_WIDTH'(1);
      deny = ((pte.ppn & low_mask) != '0) || !pte.a || ((r.priv == priv_super) && pte.u);
      case (r.access)
        access_fetch: deny = deny || !pte.x;
        access_load:  deny = deny || !pte.r;
        default:      deny = deny || !(pte.w && pte.d);
      endcase
      ppn       = (pte.ppn & ~low_mask) | (vpn & low_mask); // superpage fill-in.
      res.paddr = {ppn, r.vaddr[PAGE_OFFSET_WIDTH-1:0]};
      res.fault = deny ? kind : fault_none;
      return res;
    end
    if (lvl == 0) begin
      res.fault = kind;
      return res;
    end
    ppn = pte.ppn;
  end
  return res;
endfunction

`endif

// ==== tests/mmu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mmu_tb;
  import mmu_pkg::*;
  import walk_pkg::*;

  localparam int BARE_REQS      = 16;
  localparam int DIRECTED_REQS  = 32;
  localparam int RANDOM_REQS    = 200;
  localparam int CYCLES_PER_REQ = 400;
  localparam int MAX_CYCLES     = (BARE_REQS + DIRECTED_REQS + RANDOM_REQS) * CYCLES_PER_REQ
                                + 2 * PTE_MEM_DEPTH;
  // pte flag bits d a g u x w r v.
  localparam logic [7:0] F_PTR   = 8'b0000_0001;
  localparam logic [7:0] F_RWX   = 8'b1100_1111;
  localparam logic [7:0] F_RO    = 8'b1100_0011;
  localparam logic [7:0] F_CLEAN = 8'b0100_0111;
  localparam logic [7:0] F_USER  = 8'b1101_1111;
  localparam logic [7:0] F_WNR   = 8'b1100_0101;
  localparam logic [7:0] F_NOA   = 8'b1000_1111;

  logic                      clk;
  logic                      reset;
  logic                      req_v;
  mmu_req_s                  req;
  logic                      credit;
  logic                      resp_v;
  logic [PADDR_WIDTH-1:0]    resp_paddr;
  fault_e                    resp_fault;
  logic [PPN_WIDTH-1:0]      base_ppn;
  logic                      translation_en;
  logic                      flush;
  logic                      pre_v;
  logic [PTE_ADDR_WIDTH-1:0] pre_addr;
  pte_s                      pre_data;
  logic                      busy;

  int sent_cnt   = 0;
  int resp_cnt   = 0;
  int credit_cnt = 0;
  int checks     = 0;
  int errors     = 0;
  int cycles     = 0;

  `include "mmu_model.svh"

  expect_s exp_q [$];
  expect_s exp_head;

  tb_clk_gen #(.PERIOD(100)) u_clk (.clk_o(clk));

  mmu_top UUT (
    .clk_i            (clk),
    .reset_i          (reset),
    .req_v_i          (req_v),
    .req_i            (req),
    .credit_o         (credit),
    .resp_v_o         (resp_v),
    .resp_paddr_o     (resp_paddr),
    .resp_fault_o     (resp_fault),
    .base_ppn_i       (base_ppn),
    .translation_en_i (translation_en),
    .flush_i          (flush),
    .pre_v_i          (pre_v),
    .pre_addr_i       (pre_addr),
    .pre_data_i       (pre_data),
    .busy_o           (busy)
  );

  task automatic check_value(string what, logic [63:0] got, logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ==============================
  // stimulus helpers
  // ==============================
  task automatic send(mmu_req_s r);
    wait (sent_cnt - credit_cnt < CLIENT_CREDITS);
    @(negedge clk);
    req_v = 1'b1;
    req   = r;
    exp_q.push_back(ref_translate(r, translation_en, base_ppn));
    sent_cnt++;
    @(negedge clk);
    req_v = 1'b0;
  endtask

  task automatic translate(int vpn2, int vpn1, int vpn0, access_e acc, priv_e priv);
    mmu_req_s r;
    r.vaddr  = {VPN_SLICE_WIDTH'(vpn2), VPN_SLICE_WIDTH'(vpn1), VPN_SLICE_WIDTH'(vpn0),
                PAGE_OFFSET_WIDTH'($urandom)};
    r.access = acc;
    r.priv   = priv;
    send(r);
  endtask

  task automatic preload(int idx, logic [PPN_WIDTH-1:0] ppn, logic [7:0] flags);
    pre_v          = 1'b1;
    pre_addr       = PTE_ADDR_WIDTH'(idx);
    pre_data       = make_pte(ppn, flags);
    shadow_mem[idx] = pre_data;
    @(negedge clk);
    pre_v = 1'b0;
  endtask

  task automatic pulse_flush();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
  endtask

  task automatic wait_idle();
    wait (resp_cnt == sent_cnt);
    @(negedge clk);
  endtask

  // ==============================
  // response checker and timeout
  // ==============================
  always @(negedge clk) begin
    if (!reset && (credit || resp_v)) begin
      check_value("credit with response", 64'(credit), 64'(resp_v));
    end
    if (!reset && credit) begin
      if (credit_cnt >= sent_cnt) begin
        errors++;
        $display("credit returned with no request outstanding at %0t ns", $time);
      end else begin
        credit_cnt++;
      end
    end
    if (!reset && resp_v) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("response arrived with no request outstanding at %0t ns", $time);
      end else begin
        exp_head = exp_q.pop_front();
        check_value("fault", 64'(resp_fault), 64'(exp_head.fault));
        if (exp_head.fault == fault_none) begin
          check_value("paddr", 64'(resp_paddr), 64'(exp_head.paddr));
        end
        check_value("busy at response", 64'(busy), 64'd0); // walker done by now.
        resp_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the DUT stopped answering after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    mmu_req_s r;
    reset          = 1'b1;
    req_v          = 1'b0;
    req            = '0;
    base_ppn       = '0;
    translation_en = 1'b0;
    flush          = 1'b0;
    pre_v          = 1'b0;
    pre_addr       = '0;
    pre_data       = '0;
    void'($urandom(32'hf23f));
    repeat (10) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < PTE_MEM_DEPTH; i++) begin
      preload(i, PPN_WIDTH'(i), 8'h00); // invalid pte holding its own address.
    end
    for (int i = 0; i < BARE_REQS; i++) begin
      r.vaddr  = VADDR_WIDTH'({$urandom, $urandom});
      r.access = access_e'($urandom_range(2));
      r.priv   = priv_e'($urandom_range(1));
      send(r);
    end
    wait_idle();
    // root at ppn 0, L1 at ppn 1, L0 at ppn 2.
    preload(0, 44'd1, F_PTR);
    preload(1, 44'h40000, F_RWX);   // gigapage.
    preload(2, 44'h40200, F_RWX);   // misaligned gigapage.
    preload(512, 44'd2, F_PTR);
    preload(513, 44'hA00, F_RWX);   // megapage.
    preload(514, 44'hA01, F_RWX);   // misaligned megapage.
    preload(1025, 44'h12345, F_RWX);
    preload(1026, 44'h22222, F_RO);
    preload(1027, 44'h33333, F_CLEAN);
    preload(1029, 44'h55555, F_USER);
    preload(1030, 44'h66666, 8'b1100_1110);
    preload(1031, 44'h77777, F_WNR);
    preload(1032, 44'h88888, F_NOA);
    translation_en = 1'b1;
    translate(0, 0, 1, access_load, priv_user);
    translate(0, 0, 1, access_load, priv_user);
    translate(0, 0, 1, access_store, priv_super);
    translate(0, 1, 5, access_load, priv_user);
    translate(1, 7, 9, access_fetch, priv_super);
    translate(0, 2, 3, access_store, priv_user);
    translate(2, 0, 0, access_fetch, priv_user);
    translate(0, 0, 2, access_store, priv_user);
    translate(0, 0, 2, access_fetch, priv_user);
    translate(0, 0, 3, access_store, priv_user);
    translate(0, 0, 3, access_load, priv_user);
    translate(0, 0, 5, access_load, priv_super);
    translate(0, 0, 5, access_load, priv_user);
    translate(0, 0, 6, access_load, priv_user);
    translate(0, 0, 7, access_store, priv_user);
    translate(0, 0, 8, access_load, priv_user);
    // remap a cached page, then flush.
    translate(0, 0, 1, access_load, priv_user);
    wait_idle();
    preload(1025, 44'h54321, F_RWX);
    pulse_flush();
    translate(0, 0, 1, access_load, priv_user);
    wait_idle();
    for (int i = 0; i < 64; i++) begin
      preload(1536 + i, PPN_WIDTH'($urandom), 8'($urandom) | 8'h41);
    end
    preload(515, 44'd3, F_PTR);
    pulse_flush();
    for (int i = 0; i < RANDOM_REQS; i++) begin
      translate($urandom_range(3), $urandom_range(3), $urandom_range(63),
                access_e'($urandom_range(2)), priv_e'($urandom_range(1)));
    end
    wait_idle();
    check_value("credit count", 64'(credit_cnt), 64'(sent_cnt));
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mmu_top.f ====
+incdir+tests
common/mmu_pkg.sv
common/walk_pkg.sv
ptw/ptw_walker.sv
rtl/tlb_stage.sv
rtl/pte_mem.sv
rtl/mmu_top.sv
tests/tb_clk_gen.sv
tests/mmu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the MMU testbench with Verilator, run it, and check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f mmu_top.f --top-module mmu_tb -o mmu_sim

./obj_dir/mmu_sim 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
fi
exit 1
